//--- flist.f
+incdir+tb
verilog/adc_pkg.sv
verilog/video_pkg.sv
verilog/trace_column_if.sv
verilog/minmax_capture.sv
verilog/raster_tracker.sv
verilog/trace_buffer.sv
verilog/trace_renderer.sv
verilog/tiny_scope.sv
tb/tiny_scope_tb.sv

//--- Bender.yml
package:
  name: tiny_scope

sources:
  - files:
      - verilog/adc_pkg.sv
      - verilog/video_pkg.sv
      - verilog/trace_column_if.sv
      - verilog/minmax_capture.sv
      - verilog/raster_tracker.sv
      - verilog/trace_buffer.sv
      - verilog/trace_renderer.sv
      - verilog/tiny_scope.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tiny_scope_tb.sv

//--- tb/tiny_scope_checks.svh
//////////////////////////////
// compare tasks and expected pixel model
// included inside tiny_scope_tb, uses its model state
//////////////////////////////

`ifndef TINY_SCOPE_CHECKS_SVH
`define TINY_SCOPE_CHECKS_SVH

// one colour result against the model
task automatic compare_rgb(input string name, input rgb_t got, input rgb_t exp,
	input coord_t px, input coord_t py);
	if (got !== exp) begin
		err_pixel++;
		$display("[FAIL] %s got %06h expected %06h at x=%0h y=%0h", name, got, exp, px, py);
	end
endtask

// buffer write pointer against the expected scroll position
task automatic compare_addr(input string name, input col_addr_t got, input col_addr_t exp);
	if (got !== exp) begin
		err_other++;
		$display("[FAIL] %s got %03h expected %03h", name, got, exp);
	end
endtask

// window test straight from the raster rules
function automatic logic window_hit(input coord_t px, input coord_t py);
	return (py >= V_START) && (py < V_START + WIN_ROWS) && (px >= H_START) && (px <= H_END);
endfunction

// colour for a pixel whose x/y were registered two cycles back
function automatic rgb_t expected_pixel(input coord_t px, input coord_t py, input logic win,
	output logic known);
	col_addr_t a;
	int r;
	int ofs;
	rgb_t c;
	known = 1'b1;
	if (!win)
		return COLOR_BLACK;
	// newest column sits at H_END, older ones to the left
	a = col_addr_t'(int'(m_wr) - (H_END - H_START) + int'(px) - H_START);
	if (!m_valid[a]) begin
		known = 1'b0;
		return COLOR_BLACK;
	end
	r = int'(py) - V_START;
	for (int ch = 0; ch < NUM_CH; ch++) begin
		ofs = r - int'(CH_ROW_BASE[ch]);
		if (ofs >= 0 && ofs >= int'(m_min[a][ch][6:1]) && ofs <= int'(m_max[a][ch][6:1]))
			return CH_COL[ch];
	end
	c = BG;
	if (m_mark[a] || (int'(py) % 32 == GRID_ROW_PHASE))
		c = COLOR_GRID;
	return c;
endfunction

`endif

//--- tb/tiny_scope_tb.sv
//////////////////////////////
// directed testbench for tiny_scope
// compact timing: 40+8 pixels, 120 lines, 4 vsync lines
// every pixel is checked against a model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tiny_scope_tb import adc_pkg::*, video_pkg::*;;

	localparam int V_START = 10;
	localparam int H_START = 8;
	localparam int H_END = 23;
	localparam int N = 2;
	localparam rgb_t BG = 24'h1d1d1d;
	localparam int LINE_CYC = 48;
	localparam int FRAME_CYC = LINE_CYC * 120;
	localparam int TOTAL_FRAMES = 43;
	localparam int LIMIT = (TOTAL_FRAMES * FRAME_CYC + 100) * 3 / 2;
	localparam rgb_t CH_COL [NUM_CH] = '{COLOR_A0, COLOR_A1, COLOR_B0, COLOR_B1};

	logic clk = 1'b0;
	logic reset, blank, vsync, ad_strobe;
	sample_t ad_a0, ad_a1, ad_b0, ad_b1;
	logic [7:0] red, green, blue;

	// column model
	ch_trace_t m_min [COL_DEPTH];
	ch_trace_t m_max [COL_DEPTH];
	logic m_mark [COL_DEPTH];
	logic m_valid [COL_DEPTH];
	col_addr_t m_wr;
	int m_fcnt, m_sec;
	ch_samples_t acc_min, acc_max;
	logic acc_have, acc_started, acc_mark, drv_vs;
	ch_trace_t pend_min, pend_max;
	logic pend_mark, pend_valid;
	// raster model and 2 stage latency pipe
	coord_t mx, my, p1x, p1y, p2x, p2y;
	logic mblank_d, p1w, p2w, check_en, known;
	rgb_t exp_pix;
	int err_pixel, err_other, n_grid, n_bg, n_band, n_black, n_skip, cycles;
	integer seed = 32'hf598;

	`include "tiny_scope_checks.svh"

	tiny_scope #(.V_START(V_START), .H_START(H_START), .H_END(H_END), .N(N),
		.BG_COLOR(BG)) u_tiny_scope (.clk(clk), .reset(reset), .blank(blank),
		.vsync(vsync), .ad_a0(ad_a0), .ad_a1(ad_a1), .ad_b0(ad_b0), .ad_b1(ad_b1),
		.ad_strobe(ad_strobe), .red(red), .green(green), .blue(blue));

	always #5 clk = !clk;

	always @(posedge clk) begin
		if (reset) begin
			mx <= '0;
			my <= '0;
			mblank_d <= 1'b0;
			p1w <= 1'b0;
			p2w <= 1'b0;
		end else begin
			mblank_d <= blank;
			mx <= blank ? coord_t'(0) : mx + coord_t'(1);
			if (vsync)
				my <= '0;
			else if (blank && !mblank_d)
				my <= my + coord_t'(1);
			{p1x, p1y, p1w} <= {mx, my, window_hit(mx, my)};
			{p2x, p2y, p2w} <= {p1x, p1y, p1w};
		end
	end

	always @(negedge clk) begin
		if (check_en) begin
			exp_pix = expected_pixel(p2x, p2y, p2w, known);
			if (!known) begin
				n_skip++;
			end else begin
				compare_rgb("{red,green,blue}", {red, green, blue}, exp_pix, p2x, p2y);
				if (exp_pix == COLOR_BLACK)
					n_black++;
				else if (exp_pix == COLOR_GRID)
					n_grid++;
				else if (exp_pix == BG)
					n_bg++;
				else
					n_band++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", LIMIT);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// capture model events
	//////////////////////////////
	task automatic model_close();
		for (int c = 0; c < NUM_CH; c++) begin
			pend_min[c] = acc_min[c][11:5];
			pend_max[c] = acc_max[c][11:5];
		end
		pend_valid = acc_started && acc_have;
		pend_mark = acc_mark;
		acc_mark = (m_sec == 0);
		acc_started = 1'b1;
		acc_have = 1'b0;
	endtask

	task automatic model_fall();
		if (m_fcnt == 0) begin
			m_wr = m_wr + col_addr_t'(1);
			m_min[m_wr] = pend_min;
			m_max[m_wr] = pend_max;
			m_mark[m_wr] = pend_mark;
			m_valid[m_wr] = pend_valid;
		end
		m_fcnt = (m_fcnt + 1) % N;
		m_sec = (m_sec + 1) % FRAMES_PER_SEC;
		if (m_sec == 0)
			acc_mark = 1'b1;
	endtask

	task automatic drive_cycle(input logic bl, input logic vs, input logic stb,
		input ch_samples_t s);
		@(posedge clk);
		#1;
		if (vs && !drv_vs && m_fcnt == 0)
			model_close();
		if (!vs && drv_vs)
			model_fall();
		drv_vs = vs;
		{blank, vsync, ad_strobe} = {bl, vs, stb};
		{ad_b1, ad_b0, ad_a1, ad_a0} = s;
		if (stb) begin
			for (int c = 0; c < NUM_CH; c++) begin
				if (!acc_have || s[c] < acc_min[c])
					acc_min[c] = s[c];
				if (!acc_have || s[c] > acc_max[c])
					acc_max[c] = s[c];
			end
			acc_have = 1'b1;
		end
	endtask

	// one frame, constant level or random samples, extremes on unstrobed cycles
	task automatic drive_frame(input logic rnd, input ch_samples_t level);
		logic bl, vs, stb;
		ch_samples_t s;
		for (int line = 0; line < 120; line++) begin
			for (int cyc = 0; cyc < LINE_CYC; cyc++) begin
				bl = (cyc >= 40);
				vs = (line < 4);
				stb = !bl && !vs && (!rnd || (($random(seed) & 3) != 0));
				s = level;
				for (int c = 0; c < NUM_CH; c++) begin
					if (rnd)
						s[c] = sample_t'(12'h180 + ($random(seed) & 32'h1ff));
					if (!stb)
						s[c] = cyc[0] ? 12'hfff : 12'h000;
				end
				drive_cycle(bl, vs, stb, s);
			end
		end
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic test_reset_black();
		{reset, blank, vsync, ad_strobe} = 4'b1100;
		{ad_a0, ad_a1, ad_b0, ad_b1} = '0;
		m_wr = col_addr_t'(H_END - H_START);
		m_fcnt = 0;
		m_sec = 0;
		{acc_have, acc_started, acc_mark, drv_vs} = 4'b0010;
		for (int i = 0; i < COL_DEPTH; i++)
			m_valid[i] = 1'b0;
		repeat (4) begin
			@(posedge clk);
			check_en = 1'b1;
		end
		#1;
		reset = 1'b0;
	endtask

	task automatic test_constant_fill();
		int skip_before;
		for (int f = 0; f < 33; f++) begin
			skip_before = n_skip;
			drive_frame(1'b0, {12'h0a0, 12'h100, 12'h200, 12'h400});
		end
		if (n_skip != skip_before) begin
			err_other++;
			$display("error: window still shows unwritten columns after the fill");
		end
	endtask

	task automatic test_random_window();
		repeat (4)
			drive_frame(1'b1, '0);
	endtask

	// a column every second frame only, the first frame here closes no column
	task automatic test_scroll_rate();
		col_addr_t w0;
		col_addr_t w1;
		col_addr_t w2;
		w0 = m_wr;
		w1 = w0 + col_addr_t'(1);
		w2 = w0 + col_addr_t'(2);
		drive_frame(1'b0, {12'h040, 12'h0c0, 12'h300, 12'h7e0});
		compare_addr("wr_addr", u_tiny_scope.u_buffer.wr_addr, w0);
		drive_frame(1'b0, {12'h040, 12'h0c0, 12'h300, 12'h7e0});
		compare_addr("wr_addr", u_tiny_scope.u_buffer.wr_addr, w1);
		drive_frame(1'b0, {12'h020, 12'h020, 12'h020, 12'h020});
		compare_addr("wr_addr", u_tiny_scope.u_buffer.wr_addr, w1);
		drive_frame(1'b0, {12'h020, 12'h020, 12'h020, 12'h020});
		compare_addr("wr_addr", u_tiny_scope.u_buffer.wr_addr, w2);
	endtask

	task automatic test_grid_background();
		drive_frame(1'b0, {12'h020, 12'h020, 12'h020, 12'h020});
		drive_frame(1'b0, {12'h020, 12'h020, 12'h020, 12'h020});
		if (n_grid == 0 || n_bg == 0 || n_black == 0 || n_band == 0) begin
			err_other++;
			$display("error: a pixel class was never checked (grid %0d bg %0d black %0d band %0d)",
				n_grid, n_bg, n_black, n_band);
		end
	endtask

	initial begin
		check_en = 1'b0;
		cycles = 0;
		err_pixel = 0;
		err_other = 0;
		n_grid = 0;
		n_bg = 0;
		n_band = 0;
		n_black = 0;
		n_skip = 0;
		test_reset_black();
		test_constant_fill();
		test_random_window();
		test_scroll_rate();
		test_grid_background();
		$display("errors: pixel %0d other %0d, pixels checked %0d, unchecked %0d",
			err_pixel, err_other, n_grid + n_bg + n_band + n_black, n_skip);
		if (err_pixel + err_other == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/tiny_scope.sv
//////////////////////////////
// small scrolling scope, single clock
// samples arrive on clk, qualified by ad_strobe
// colour lags x/y registration by 2 cycles
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tiny_scope import adc_pkg::*, video_pkg::*; #(
	parameter int V_START = 363,
	parameter int H_START = 500,
	parameter int H_END = 799,
	// frames per column, 1 to 15
	parameter int N = 3,
	parameter rgb_t BG_COLOR = 24'h1d1d1d
) (
	input wire clk,
	input wire reset,
	input wire blank,
	input wire vsync,
	input wire sample_t ad_a0,
	input wire sample_t ad_a1,
	input wire sample_t ad_b0,
	input wire sample_t ad_b1,
	input wire ad_strobe,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	ch_samples_t samples;
	coord_t x;
	coord_t y;
	logic in_window;
	ch_trace_t rd_min;
	ch_trace_t rd_max;
	logic rd_mark;

	trace_column_if col_if ();

	// index 0 is A0
	assign samples = {ad_b1, ad_b0, ad_a1, ad_a0};

	minmax_capture #(.N(N)) u_capture (.clk(clk), .reset(reset), .vsync(vsync),
		.ad_strobe(ad_strobe), .samples(samples), .col(col_if.capture));

	raster_tracker #(.V_START(V_START), .H_START(H_START), .H_END(H_END)) u_raster (
		.clk(clk), .reset(reset), .blank(blank), .vsync(vsync),
		.x(x), .y(y), .in_window(in_window));

	trace_buffer #(.H_START(H_START), .H_END(H_END)) u_buffer (.clk(clk), .reset(reset),
		.col(col_if.buffer), .x(x), .rd_min(rd_min), .rd_max(rd_max), .rd_mark(rd_mark));

	trace_renderer #(.V_START(V_START), .BG_COLOR(BG_COLOR)) u_renderer (
		.clk(clk), .reset(reset), .y(y), .in_window(in_window),
		.rd_min(rd_min), .rd_max(rd_max), .rd_mark(rd_mark),
		.red(red), .green(green), .blue(blue));

endmodule

`default_nettype wire

//--- verilog/trace_renderer.sv
//////////////////////////////
// colour per pixel from the read column
// bands use trace bits 6..1, so a channel spans 64 rows
// priority A0, A1, B0, B1, grid, background
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trace_renderer import adc_pkg::*, video_pkg::*; #(
	parameter int V_START = 363,
	parameter rgb_t BG_COLOR = 24'h1d1d1d
) (
	input wire clk,
	input wire reset,
	input wire coord_t y,
	input wire in_window,
	input wire ch_trace_t rd_min,
	input wire ch_trace_t rd_max,
	input wire rd_mark,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	localparam rgb_t CH_COLOR [NUM_CH] = '{COLOR_A0, COLOR_A1, COLOR_B0, COLOR_B1};

	coord_t y_d1;
	logic win_d1;
	coord_t row;
	logic [NUM_CH-1:0] lit;
	logic grid;
	rgb_t pix_next;
	rgb_t pix;

	// line and window flag, aligned with the memory read
	always_ff @(posedge clk) begin
		if (reset) begin
			y_d1 <= '0;
			win_d1 <= 1'b0;
		end else begin
			y_d1 <= y;
			win_d1 <= in_window;
		end
	end

	//////////////////////////////
	// band and grid tests
	//////////////////////////////
	always_comb begin
		coord_t rel;
		row = y_d1 - coord_t'(V_START);
		for (int c = 0; c < NUM_CH; c++) begin
			rel = row - CH_ROW_BASE[c];
			lit[c] = (row >= CH_ROW_BASE[c]) &&
				(rel >= coord_t'(rd_min[c][TRACE_W-1:1])) &&
				(rel <= coord_t'(rd_max[c][TRACE_W-1:1]));
		end
		// second marks give the vertical lines
		grid = rd_mark || (y_d1[4:0] == 5'(GRID_ROW_PHASE));
	end

	// walk channels from lowest priority so A0 ends on top
	always_comb begin
		pix_next = grid ? COLOR_GRID : BG_COLOR;
		for (int c = NUM_CH - 1; c >= 0; c--) begin
			if (lit[c])
				pix_next = CH_COLOR[c];
		end
		if (!win_d1)
			pix_next = COLOR_BLACK;
	end

	always_ff @(posedge clk) begin
		if (reset)
			pix <= COLOR_BLACK;
		else
			pix <= pix_next;
	end

	assign {red, green, blue} = pix;

endmodule

`default_nettype wire

//--- verilog/trace_buffer.sv
//////////////////////////////
// circular column store, 512 entries
// newest column is read out at x = H_END
// H_END - H_START must be below 512
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trace_buffer import adc_pkg::*, video_pkg::*; #(
	parameter int H_START = 500,
	parameter int H_END = 799
) (
	input wire clk,
	input wire reset,
	trace_column_if.buffer col,
	input wire coord_t x,
	output ch_trace_t rd_min,
	output ch_trace_t rd_max,
	output logic rd_mark
);

	localparam col_addr_t SPAN = col_addr_t'(H_END - H_START);
	localparam col_addr_t X_OFS = col_addr_t'(H_START);

	typedef struct packed {
		logic mark;
		ch_trace_t hi;
		ch_trace_t lo;
	} col_word_t;

	col_word_t mem [COL_DEPTH];
	col_word_t rd_word;
	col_addr_t wr_addr;
	col_addr_t wr_next;
	col_addr_t rd_addr;
	logic col_write;

	assign col_write = col.frame_end && col.window_open;
	assign wr_next = wr_addr + col_addr_t'(1);

	//////////////////////////////
	// write side
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset)
			wr_addr <= SPAN;
		else if (col_write)
			wr_addr <= wr_next;
	end

	always_ff @(posedge clk) begin
		if (col_write)
			mem[wr_next] <= '{mark: col.col_mark, hi: col.col_max, lo: col.col_min};
	end

	//////////////////////////////
	// read side
	//////////////////////////////
	// oldest shown column sits at H_START, wraps mod 512
	always_ff @(posedge clk) begin
		rd_addr <= wr_addr - SPAN + col_addr_t'(x) - X_OFS;
	end

	assign rd_word = mem[rd_addr];
	assign rd_min = rd_word.lo;
	assign rd_max = rd_word.hi;
	assign rd_mark = rd_word.mark;

endmodule

`default_nettype wire

//--- verilog/raster_tracker.sv
//////////////////////////////
// pixel and line counters from blank and vsync
// x counts from 0 after blank drops
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module raster_tracker import video_pkg::*; #(
	parameter int V_START = 363,
	parameter int H_START = 500,
	parameter int H_END = 799
) (
	input wire clk,
	input wire reset,
	input wire blank,
	input wire vsync,
	output coord_t x,
	output coord_t y,
	output logic in_window
);

	logic blank_d1;

	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d1 <= 1'b0;
			x <= '0;
			y <= '0;
		end else begin
			blank_d1 <= blank;
			x <= blank ? coord_t'(0) : x + coord_t'(1);
			// line steps on the start of each blank
			if (vsync)
				y <= '0;
			else if (blank && !blank_d1)
				y <= y + coord_t'(1);
		end
	end

	assign in_window = (y >= coord_t'(V_START)) && (y < coord_t'(V_START + WIN_ROWS)) &&
		(x >= coord_t'(H_START)) && (x <= coord_t'(H_END));

endmodule

`default_nettype wire

//--- verilog/minmax_capture.sv
//////////////////////////////
// min/max capture over N frames
// samples count only when ad_strobe is high
// N must be 1 to 15, vsync is synchronous to clk
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module minmax_capture import adc_pkg::*; #(
	parameter int N = 3
) (
	input wire clk,
	input wire reset,
	input wire vsync,
	input wire ad_strobe,
	input wire ch_samples_t samples,
	trace_column_if.capture col
);

	localparam logic [3:0] FRAME_LAST = 4'(N - 1);
	localparam logic [5:0] SEC_LAST = 6'(FRAMES_PER_SEC - 1);

	logic vsync_d1;
	logic vsync_rise;
	logic vsync_fall;
	logic close_win;
	logic [3:0] frame_cnt;
	logic [5:0] sec_cnt;
	logic run_empty;
	logic run_mark;
	ch_samples_t run_min;
	ch_samples_t run_max;

	assign vsync_rise = vsync && !vsync_d1;
	assign vsync_fall = !vsync && vsync_d1;
	// rising edge of the frame that ends a window
	assign close_win = vsync_rise && (frame_cnt == 4'd0);

	//////////////////////////////
	// frame and second counters
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d1 <= 1'b0;
			frame_cnt <= 4'd0;
			sec_cnt <= 6'd0;
			col.frame_end <= 1'b0;
			col.window_open <= 1'b0;
		end else begin
			vsync_d1 <= vsync;
			col.frame_end <= vsync_fall;
			if (vsync_fall) begin
				// counter value before the step decides the write
				col.window_open <= (frame_cnt == 4'd0);
				frame_cnt <= (frame_cnt == FRAME_LAST) ? 4'd0 : frame_cnt + 4'd1;
				sec_cnt <= (sec_cnt == SEC_LAST) ? 6'd0 : sec_cnt + 6'd1;
			end
		end
	end

	// second mark and empty flag for the running window
	always_ff @(posedge clk) begin
		if (reset) begin
			run_empty <= 1'b1;
			run_mark <= 1'b0;
			col.col_mark <= 1'b0;
		end else begin
			if (close_win) begin
				col.col_mark <= run_mark;
				run_mark <= (sec_cnt == 6'd0);
				run_empty <= !ad_strobe;
			end else begin
				run_mark <= run_mark || (sec_cnt == 6'd0);
				if (ad_strobe)
					run_empty <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// per channel min/max
	//////////////////////////////
	always_ff @(posedge clk) begin
		for (int c = 0; c < NUM_CH; c++) begin
			if (close_win) begin
				col.col_min[c] <= run_min[c][SAMPLE_W-1 -: TRACE_W];
				col.col_max[c] <= run_max[c][SAMPLE_W-1 -: TRACE_W];
			end
			if (ad_strobe) begin
				// first strobed sample of a window seeds both values
				if (run_empty || close_win) begin
					run_min[c] <= samples[c];
					run_max[c] <= samples[c];
				end else begin
					if (samples[c] < run_min[c])
						run_min[c] <= samples[c];
					if (samples[c] > run_max[c])
						run_max[c] <= samples[c];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/trace_column_if.sv
//////////////////////////////
// one column summary per frame window
// no back-pressure, the buffer always takes it
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface trace_column_if import adc_pkg::*; ();

	// min/max trace bits per channel, valid while frame_end is high
	ch_trace_t col_min;
	ch_trace_t col_max;
	// a second tick fell inside this window
	logic col_mark;
	// one cycle pulse after the falling vsync edge
	logic frame_end;
	// this frame closes a column
	logic window_open;

	modport capture (output col_min, col_max, col_mark, frame_end, window_open);

	modport buffer (input col_min, col_max, col_mark, frame_end, window_open);

endinterface

`default_nettype wire

//--- verilog/video_pkg.sv
//////////////////////////////
// raster and colour definitions
// trace buffer holds 512 columns, so the window
// is at most 512 pixels wide
//////////////////////////////

`default_nettype none

package video_pkg;

	// raster column or line count
	typedef logic [9:0] coord_t;

	// trace buffer column address
	typedef logic [8:0] col_addr_t;
	localparam int COL_DEPTH = 2 ** $bits(col_addr_t);

	// 8 bits each of red, green, blue
	typedef logic [23:0] rgb_t;

	//////////////////////////////
	// palette
	//////////////////////////////
	localparam rgb_t COLOR_A0 = 24'hffffff;
	localparam rgb_t COLOR_A1 = 24'hff0000;
	localparam rgb_t COLOR_B0 = 24'h00ff00;
	localparam rgb_t COLOR_B1 = 24'h0000ff;
	localparam rgb_t COLOR_GRID = 24'h808080;
	localparam rgb_t COLOR_BLACK = 24'h000000;

	// window height in lines
	localparam int WIN_ROWS = 96;

	// band base row inside the window, A0 to B1
	localparam coord_t CH_ROW_BASE [4] = '{10'd40, 10'd56, 10'd72, 10'd88};

	// grid on lines where y mod 32 equals this
	localparam int GRID_ROW_PHASE = 8;

endpackage

`default_nettype wire

//--- verilog/adc_pkg.sv
//////////////////////////////
// ADC side types for the tiny scope
// four 12 bit channels, order A0, A1, B0, B1
// only the top 7 bits of a sample are kept in the trace
//////////////////////////////

`default_nettype none

package adc_pkg;

	// channel count and widths
	localparam int NUM_CH = 4;
	localparam int SAMPLE_W = 12;
	localparam int TRACE_W = 7;

	// one raw sample as delivered by the converter
	typedef logic [SAMPLE_W-1:0] sample_t;

	// stored trace value, sample bits 11..5
	typedef logic [TRACE_W-1:0] trace_t;

	// index 0 is A0, index 3 is B1
	typedef sample_t [NUM_CH-1:0] ch_samples_t;
	typedef trace_t [NUM_CH-1:0] ch_trace_t;

	// frame ticks per second mark, assumes 60 Hz video
	localparam int FRAMES_PER_SEC = 60;

endpackage

`default_nettype wire
